/* src.f */
design/mips_isa_pkg.sv
design/pipe_ctrl_pkg.sv
design/pipe_reg.sv
design/ifetch.sv
design/idecode.sv
design/forward.sv
design/execute.sv
design/mycpu_top.sv
testbench/tb_mycpu_top.sv

/* Bender.yml */
package:
  name: mycpu_pipeline

sources:
  - design/mips_isa_pkg.sv
  - design/pipe_ctrl_pkg.sv
  - design/pipe_reg.sv
  - design/ifetch.sv
  - design/idecode.sv
  - design/forward.sv
  - design/execute.sv
  - design/mycpu_top.sv
  - target: test
    files:
      - testbench/tb_mycpu_top.sv

/* testbench/program_cases.txt */
# I <instruction word> in fetch order from the reset pc | D <byte address> <data word>
# T <test name> <pc> <register number> <written value> in writeback order
D 00000044 cafef00d
I 3c011234
I 34218765
I 2402fffb
I 00221821
I 00612023
I 00242824
I 00223026
I 00c53825
I 0041402a
I 0022482a
I 00015100
I 240b0040
I ad610000
I 8d6c0000
I 018c6821
I 8d6e0004
I 25c00001
I 000e7821
I 10230002
I 24100001
I 24110002
I 14230002
I 24120003
I 24137bad
I 24140001
I 12900002
I 26950001
I 24137bad
I 16900005
I 24160004
I 0bf00021
I 24170005
I 24137bad
I 0ff00024
I 24180006
I 24137bad
I 03e0c821
I 1000ffff
I ad600008
T alu_lui        bfc00000 1  12340000
T alu_ori_zext   bfc00004 1  12348765
T alu_addiu_neg  bfc00008 2  fffffffb
T fwd_addu       bfc0000c 3  12348760
T fwd_subu       bfc00010 4  fffffffb
T fwd_and        bfc00014 5  12348761
T alu_xor        bfc00018 6  edcb789e
T fwd_or         bfc0001c 7  ffffffff
T alu_slt_true   bfc00020 8  00000001
T alu_slt_false  bfc00024 9  00000000
T alu_sll        bfc00028 10 23487650
T mem_base       bfc0002c 11 00000040
T mem_sw_lw      bfc00034 12 12348765
T loaduse_addu   bfc00038 13 24690eca
T mem_lw_init    bfc0003c 14 cafef00d
T r0_write       bfc00040 0  cafef00e
T r0_read        bfc00044 15 cafef00d
T beq_nt_slot    bfc0004c 16 00000001
T beq_nt_fall    bfc00050 17 00000002
T bne_t_slot     bfc00058 18 00000003
T br_operand     bfc00060 20 00000001
T beq_t_slot     bfc00068 21 00000002
T bne_nt_slot    bfc00074 22 00000004
T j_slot         bfc0007c 23 00000005
T jal_link       bfc00084 31 bfc0008c
T jal_slot       bfc00088 24 00000006
T jal_fwd_ra     bfc00090 25 bfc0008c

/* testbench/tb_mycpu_top.sv */
module tb_mycpu_top;
    timeunit 1ns;
    timeprecision 1ps;

    import mips_isa_pkg::*;

    localparam int  MEM_WORDS    = 256;
    localparam int  MAX_TRACE    = 64;
    localparam int  DRAIN_CYCLES = 8;     // catches stray writes after the last entry
    localparam real CLK_HALF     = 2.0;
    localparam real DRIVE_DELAY  = 0.5;

    logic                  clk;
    logic                  rst_n;
    logic [WORD_W-1:0]     inst_sram_addr;
    logic [WORD_W-1:0]     inst_sram_rdata;
    logic [3:0]            data_sram_wen;
    logic [WORD_W-1:0]     data_sram_addr;
    logic [WORD_W-1:0]     data_sram_wdata;
    logic [WORD_W-1:0]     data_sram_rdata;
    logic [WORD_W-1:0]     debug_wb_pc;
    logic [3:0]            debug_wb_rf_wen;
    logic [REG_ADDR_W-1:0] debug_wb_rf_wnum;
    logic [WORD_W-1:0]     debug_wb_rf_wdata;

    logic [WORD_W-1:0] imem [MEM_WORDS];
    logic [WORD_W-1:0] dmem [MEM_WORDS];
    logic [8*24-1:0]   exp_name [MAX_TRACE];
    logic [WORD_W-1:0] exp_pc [MAX_TRACE];
    int                exp_reg [MAX_TRACE];
    logic [WORD_W-1:0] exp_val [MAX_TRACE];

    int n_prog;
    int n_exp;
    int seen;             // trace entries consumed so far
    int mismatch_errors;
    int missing_errors;
    int extra_errors;
    int setup_errors;
    logic loaded;
    logic timed_out;

    logic [7:0]        inst_idx;   // requests sampled mid cycle
    logic [7:0]        data_idx;
    logic [3:0]        wen_q;
    logic [WORD_W-1:0] wdata_q;

    mycpu_top u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .inst_sram_addr   (inst_sram_addr),
        .inst_sram_rdata  (inst_sram_rdata),
        .data_sram_wen    (data_sram_wen),
        .data_sram_addr   (data_sram_addr),
        .data_sram_wdata  (data_sram_wdata),
        .data_sram_rdata  (data_sram_rdata),
        .debug_wb_pc      (debug_wb_pc),
        .debug_wb_rf_wen  (debug_wb_rf_wen),
        .debug_wb_rf_wnum (debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    always @(negedge clk) begin
        inst_idx = inst_sram_addr[9:2];
        data_idx = data_sram_addr[9:2];
        wen_q    = data_sram_wen;
        wdata_q  = data_sram_wdata;
    end

    // sram read data returns after the edge and a write lands at that edge
    always @(posedge clk) begin
        #(DRIVE_DELAY);
        inst_sram_rdata = imem[inst_idx];
        data_sram_rdata = dmem[data_idx];  // old word on a same address write
        for (int b = 0; b < 4; b++) begin
            if (wen_q[b]) begin
                dmem[data_idx][8*b +: 8] = wdata_q[8*b +: 8];
            end
        end
    end

    task automatic load_cases();
        int                fd;
        int                n;
        logic [8*160-1:0]  line;
        logic [8*16-1:0]   tag;
        logic [8*24-1:0]   name;
        logic [WORD_W-1:0] word;
        logic [WORD_W-1:0] addr;
        int                rnum;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = 32'hdc00_0000 | (i << 2);  // undefined opcode
            dmem[i] = 32'h5a5a_0000 ^ (i << 2);
        end
        fd = $fopen("testbench/program_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file testbench/program_cases.txt");
            setup_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s", tag);
                if (n == 1 && tag == "I" && n_prog < MEM_WORDS) begin
                    n = $sscanf(line, "%s %h", tag, word);
                    imem[n_prog] = word;
                    n_prog++;
                end else if (n == 1 && tag == "D") begin
                    n = $sscanf(line, "%s %h %h", tag, addr, word);
                    dmem[addr[9:2]] = word;
                end else if (n == 1 && tag == "T" && n_exp < MAX_TRACE) begin
                    n = $sscanf(line, "%s %s %h %d %h", tag, name, addr, rnum, word);
                    exp_name[n_exp] = name;
                    exp_pc[n_exp]   = addr;
                    exp_reg[n_exp]  = rnum;
                    exp_val[n_exp]  = word;
                    n_exp++;
                end else if (n == 1 && tag != "#") begin
                    $display("case file line with unknown tag %0s", tag);
                    setup_errors++;
                end
            end
        end
        $fclose(fd);
        if (n_prog == 0 || n_exp == 0) begin
            $display("case file holds no program words or no trace entries");
            setup_errors++;
        end
    endtask

    task automatic check_writeback();
        if (seen >= n_exp) begin
            $display("extra writeback after the expected trace: pc %h r%0d = %h",
                     debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata);
            extra_errors++;
        end else begin
            assert (debug_wb_rf_wen == 4'hf && debug_wb_pc == exp_pc[seen]
                    && debug_wb_rf_wnum == exp_reg[seen]
                    && debug_wb_rf_wdata == exp_val[seen])
            else begin
                $display("error %0s: expected pc %h r%0d = %h, actual pc %h r%0d = %h",
                         exp_name[seen], exp_pc[seen], exp_reg[seen], exp_val[seen],
                         debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata);
                mismatch_errors++;
            end
        end
        seen++;
    endtask

    task automatic report_missing();
        for (int i = seen; i < n_exp; i++) begin
            $display("trace entry %0s never appeared: pc %h was to write r%0d",
                     exp_name[i], exp_pc[i], exp_reg[i]);
            missing_errors++;
        end
    endtask

    task automatic finish_run();
        int total;
        total = mismatch_errors + missing_errors + extra_errors + setup_errors;
        $display("errors: %0d mismatched, %0d missing, %0d extra, %0d setup",
                 mismatch_errors, missing_errors, extra_errors, setup_errors);
        if (total == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    always @(negedge clk) begin
        if (rst_n && loaded && debug_wb_rf_wen != 4'b0) begin
            check_writeback();
        end
    end

    initial begin
        rst_n           = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        loaded          = 1'b0;
        timed_out       = 1'b0;
        n_prog          = 0;
        n_exp           = 0;
        seen            = 0;
        mismatch_errors = 0;
        missing_errors  = 0;
        extra_errors    = 0;
        setup_errors    = 0;
        load_cases();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        wait (seen >= n_exp);
        repeat (DRAIN_CYCLES) @(posedge clk);
        finish_run();
    end

    // budget scales with the program length
    initial begin
        wait (loaded);
        repeat (20 * n_prog + 50) @(posedge clk);
        $display("watchdog expired after %0d cycles with %0d of %0d trace entries seen",
                 20 * n_prog + 50, seen, n_exp);
        timed_out = 1'b1;
        report_missing();
        finish_run();
    end

endmodule

/* design/mycpu_top.sv */
module mycpu_top #(
    parameter logic [mips_isa_pkg::WORD_W-1:0] RESET_PC = 32'hbfc0_0000
) (
    input  logic                                clk,
    input  logic                                rst_n,
    output logic [mips_isa_pkg::WORD_W-1:0]     inst_sram_addr,
    input  logic [mips_isa_pkg::WORD_W-1:0]     inst_sram_rdata,
    output logic [3:0]                          data_sram_wen,
    output logic [mips_isa_pkg::WORD_W-1:0]     data_sram_addr,
    output logic [mips_isa_pkg::WORD_W-1:0]     data_sram_wdata,
    input  logic [mips_isa_pkg::WORD_W-1:0]     data_sram_rdata,
    output logic [mips_isa_pkg::WORD_W-1:0]     debug_wb_pc,
    output logic [3:0]                          debug_wb_rf_wen,
    output logic [mips_isa_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [mips_isa_pkg::WORD_W-1:0]     debug_wb_rf_wdata
);
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    logic [WORD_W-1:0]     fetch_pc;
    logic [WORD_W-1:0]     if_pc;        // pc of the decode word
    logic                  branch_taken;
    logic [WORD_W-1:0]     target;
    logic                  load_use_stall;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [WORD_W-1:0]     rs_value;
    logic [WORD_W-1:0]     rt_value;
    logic [WORD_W-1:0]     rs_fwd;
    logic [WORD_W-1:0]     rt_fwd;
    logic [WORD_W-1:0]     imm;
    logic [25:0]           jump_index;
    npc_op_e               npc_op;
    id_ex_t                ctrl;
    id_ex_t                id_ex_d;
    id_ex_t                id_ex_q;
    logic [WORD_W-1:0]     ex_result;
    ex_mem_t               ex_mem_d;
    ex_mem_t               ex_mem_q;
    logic [WORD_W-1:0]     mem_value;
    mem_wb_t               mem_wb_d;
    mem_wb_t               mem_wb_q;
    logic [WORD_W-1:0]     wb_wdata;

    ifetch #(.RESET_PC(RESET_PC)) u_ifetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (load_use_stall),
        .branch_taken  (branch_taken),
        .target        (target),
        .pc            (fetch_pc),
        .inst_sram_addr(inst_sram_addr)
    );

    pipe_reg #(.payload_t(logic [WORD_W-1:0])) u_if_id (
        .clk(clk), .rst_n(rst_n), .stall(load_use_stall), .bubble(1'b0),
        .d(fetch_pc), .q(if_pc)
    );

    idecode u_idecode (
        .clk(clk), .rst_n(rst_n), .inst(inst_sram_rdata),
        .wb_we(mem_wb_q.rf_we), .wb_rd(mem_wb_q.rd), .wb_wdata(wb_wdata),
        .rs(rs), .rt(rt), .rs_value(rs_value), .rt_value(rt_value),
        .imm(imm), .ctrl(ctrl), .npc_op(npc_op), .jump_index(jump_index)
    );

    // the mem stage value is the returning load word for loads
    assign mem_value = ex_mem_q.is_load ? data_sram_rdata : ex_mem_q.alu_result;

    forward u_forward (
        .rs(rs), .rt(rt), .rs_value(rs_value), .rt_value(rt_value),
        .npc_op(npc_op), .jump_index(jump_index), .imm(imm), .dec_pc(if_pc),
        .ex_rd(id_ex_q.rd), .ex_we(id_ex_q.rf_we), .ex_is_load(id_ex_q.is_load),
        .ex_result(ex_result),
        .mem_rd(ex_mem_q.rd), .mem_we(ex_mem_q.rf_we), .mem_value(mem_value),
        .rs_fwd(rs_fwd), .rt_fwd(rt_fwd), .branch_taken(branch_taken),
        .target(target), .load_use_stall(load_use_stall)
    );

    always_comb begin
        id_ex_d          = ctrl;
        id_ex_d.pc       = if_pc;
        id_ex_d.rs_value = rs_fwd;
        id_ex_d.rt_value = rt_fwd;
    end

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .bubble(load_use_stall),
        .d(id_ex_d), .q(id_ex_q)
    );

    execute u_execute (
        .ex(id_ex_q), .result(ex_result), .mem_out(ex_mem_d),
        .data_sram_wen(data_sram_wen), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .bubble(1'b0),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    assign mem_wb_d = '{pc: ex_mem_q.pc, alu_result: ex_mem_q.alu_result, rd: ex_mem_q.rd,
                        rf_we: ex_mem_q.rf_we, is_load: ex_mem_q.is_load,
                        wb_sel: ex_mem_q.wb_sel, load_word: data_sram_rdata};

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .bubble(1'b0),
        .d(mem_wb_d), .q(mem_wb_q)
    );

    // the jal link value already rides in alu_result
    always_comb begin
        case (mem_wb_q.wb_sel)
            WB_RAM:  wb_wdata = mem_wb_q.load_word;
            default: wb_wdata = mem_wb_q.alu_result;
        endcase
    end

    assign debug_wb_pc       = mem_wb_q.pc;
    assign debug_wb_rf_wen   = {4{mem_wb_q.rf_we}};
    assign debug_wb_rf_wnum  = mem_wb_q.rd;
    assign debug_wb_rf_wdata = wb_wdata;

endmodule

/* design/execute.sv */
module execute (
    input  pipe_ctrl_pkg::id_ex_t           ex,
    output logic [mips_isa_pkg::WORD_W-1:0] result,
    output pipe_ctrl_pkg::ex_mem_t          mem_out,
    output logic [3:0]                      data_sram_wen,
    output logic [mips_isa_pkg::WORD_W-1:0] data_sram_addr,
    output logic [mips_isa_pkg::WORD_W-1:0] data_sram_wdata
);
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    logic [WORD_W-1:0] op_b;
    logic [WORD_W-1:0] alu_out;

    assign op_b = ex.b_sel ? ex.imm : ex.rt_value;

    always_comb begin
        case (ex.alu_op)
            ALU_ADD: alu_out = ex.rs_value + op_b;
            ALU_SUB: alu_out = ex.rs_value - op_b;
            ALU_AND: alu_out = ex.rs_value & op_b;
            ALU_OR:  alu_out = ex.rs_value | op_b;
            ALU_XOR: alu_out = ex.rs_value ^ op_b;
            ALU_SLT: alu_out = {31'b0, $signed(ex.rs_value) < $signed(op_b)};
            ALU_SLL: alu_out = ex.rt_value << ex.imm[4:0];
            default: alu_out = {op_b[15:0], 16'b0};  // lui
        endcase
    end

    // jal forwards its link value like any alu result
    assign result = (ex.wb_sel == WB_LINK) ? ex.pc + 32'd8 : alu_out;

    assign mem_out.pc         = ex.pc;
    assign mem_out.alu_result = result;
    assign mem_out.rd         = ex.rd;
    assign mem_out.rf_we      = ex.rf_we;
    assign mem_out.is_load    = ex.is_load;
    assign mem_out.wb_sel     = ex.wb_sel;

    assign data_sram_wen   = {4{ex.is_store}};  // word stores only
    assign data_sram_addr  = alu_out;
    assign data_sram_wdata = ex.rt_value;

endmodule

/* design/forward.sv */
module forward (
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] rs,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] rt,
    input  logic [mips_isa_pkg::WORD_W-1:0]     rs_value,
    input  logic [mips_isa_pkg::WORD_W-1:0]     rt_value,
    input  pipe_ctrl_pkg::npc_op_e              npc_op,
    input  logic [25:0]                         jump_index,
    input  logic [mips_isa_pkg::WORD_W-1:0]     imm,
    input  logic [mips_isa_pkg::WORD_W-1:0]     dec_pc,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic                                ex_we,
    input  logic                                ex_is_load,
    input  logic [mips_isa_pkg::WORD_W-1:0]     ex_result,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] mem_rd,
    input  logic                                mem_we,
    input  logic [mips_isa_pkg::WORD_W-1:0]     mem_value,
    output logic [mips_isa_pkg::WORD_W-1:0]     rs_fwd,
    output logic [mips_isa_pkg::WORD_W-1:0]     rt_fwd,
    output logic                                branch_taken,
    output logic [mips_isa_pkg::WORD_W-1:0]     target,
    output logic                                load_use_stall
);
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    logic [WORD_W-1:0] pc_plus4;
    logic              taken;

    function automatic logic [WORD_W-1:0] bypass(input logic [REG_ADDR_W-1:0] src,
                                                 input logic [WORD_W-1:0]     raw);
        if (src != '0 && ex_we && !ex_is_load && ex_rd == src) begin
            return ex_result;  // youngest producer wins
        end else if (src != '0 && mem_we && mem_rd == src) begin
            return mem_value;
        end
        return raw;
    endfunction

    assign rs_fwd = bypass(rs, rs_value);
    assign rt_fwd = bypass(rt, rt_value);

    assign load_use_stall = ex_we && ex_is_load && ex_rd != '0 && (ex_rd == rs || ex_rd == rt);

    assign pc_plus4 = dec_pc + 32'd4;

    always_comb begin
        case (npc_op)
            NPC_BEQ:  taken = (rs_fwd == rt_fwd);
            NPC_BNE:  taken = (rs_fwd != rt_fwd);
            NPC_JUMP: taken = 1'b1;
            default:  taken = 1'b0;
        endcase
    end

    assign branch_taken = taken && !load_use_stall;  // retried after the bubble
    assign target = (npc_op == NPC_JUMP) ? {pc_plus4[31:28], jump_index, 2'b00}
                                         : pc_plus4 + {imm[29:0], 2'b00};

endmodule

/* design/idecode.sv */
module idecode (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [mips_isa_pkg::WORD_W-1:0]     inst,
    input  logic                                wb_we,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic [mips_isa_pkg::WORD_W-1:0]     wb_wdata,
    output logic [mips_isa_pkg::REG_ADDR_W-1:0] rs,
    output logic [mips_isa_pkg::REG_ADDR_W-1:0] rt,
    output logic [mips_isa_pkg::WORD_W-1:0]     rs_value,
    output logic [mips_isa_pkg::WORD_W-1:0]     rt_value,
    output logic [mips_isa_pkg::WORD_W-1:0]     imm,
    output pipe_ctrl_pkg::id_ex_t               ctrl,
    output pipe_ctrl_pkg::npc_op_e              npc_op,
    output logic [25:0]                         jump_index
);
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    logic [WORD_W-1:0] regs [1:31];
    logic              dec_valid;     // low until the first fetched word arrives
    logic [5:0]        opcode;
    logic [5:0]        funct;
    logic [REG_ADDR_W-1:0] rd_field;

    function automatic logic [WORD_W-1:0] rf_read(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_we && wb_rd == addr) begin
            return wb_wdata;  // write-first bypass
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= 1'b1;
        end
    end

    assign opcode     = inst[OPCODE_LSB +: 6];
    assign funct      = inst[5:0];
    assign rs         = inst[RS_LSB +: REG_ADDR_W];
    assign rt         = inst[RT_LSB +: REG_ADDR_W];
    assign rd_field   = inst[RD_LSB +: REG_ADDR_W];
    assign jump_index = inst[25:0];
    assign rs_value   = rf_read(rs);
    assign rt_value   = rf_read(rt);

    always_comb begin
        if (opcode == OP_ORI) begin
            imm = {16'b0, inst[15:0]};
        end else if (opcode == OP_SPECIAL) begin
            imm = {27'b0, inst[SA_LSB +: 5]};  // shift amount
        end else begin
            imm = {{16{inst[15]}}, inst[15:0]};
        end
    end

    always_comb begin
        ctrl        = '0;
        ctrl.imm    = imm;
        ctrl.rd     = rt;  // I-type writes rt
        npc_op      = NPC_SEQ;
        case (opcode)
            OP_SPECIAL: begin
                ctrl.rd    = rd_field;
                ctrl.rf_we = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLL:  ctrl.alu_op = ALU_SLL;
                    default: ctrl.rf_we  = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl.alu_op = ALU_ADD;
                ctrl.b_sel  = 1'b1;
                ctrl.rf_we  = 1'b1;
            end
            OP_ORI: begin
                ctrl.alu_op = ALU_OR;
                ctrl.b_sel  = 1'b1;
                ctrl.rf_we  = 1'b1;
            end
            OP_LUI: begin
                ctrl.alu_op = ALU_LUI;
                ctrl.b_sel  = 1'b1;
                ctrl.rf_we  = 1'b1;
            end
            OP_LW: begin
                ctrl.b_sel   = 1'b1;
                ctrl.rf_we   = 1'b1;
                ctrl.is_load = 1'b1;
                ctrl.wb_sel  = WB_RAM;
            end
            OP_SW: begin
                ctrl.b_sel    = 1'b1;
                ctrl.is_store = 1'b1;
            end
            OP_BEQ: npc_op = NPC_BEQ;
            OP_BNE: npc_op = NPC_BNE;
            OP_J:   npc_op = NPC_JUMP;
            OP_JAL: begin
                npc_op      = NPC_JUMP;
                ctrl.rd     = REG_RA;
                ctrl.rf_we  = 1'b1;
                ctrl.wb_sel = WB_LINK;
            end
            default: ;
        endcase
        if (!dec_valid) begin
            ctrl   = '0;
            npc_op = NPC_SEQ;
        end
    end

endmodule

/* design/ifetch.sv */
module ifetch #(
    parameter logic [mips_isa_pkg::WORD_W-1:0] RESET_PC = 32'hbfc0_0000
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            stall,
    input  logic                            branch_taken,
    input  logic [mips_isa_pkg::WORD_W-1:0] target,
    output logic [mips_isa_pkg::WORD_W-1:0] pc,
    output logic [mips_isa_pkg::WORD_W-1:0] inst_sram_addr
);
    import mips_isa_pkg::*;

    logic [WORD_W-1:0] pc_reg;     // pc of the word now returned by the sram
    logic              redir;      // redirect waits for the delay slot fetch
    logic [WORD_W-1:0] redir_pc;

    always_comb begin
        if (stall) begin
            pc = pc_reg;           // refetch the held decode word
        end else if (redir) begin
            pc = redir_pc;
        end else begin
            pc = pc_reg + 32'd4;
        end
    end

    assign inst_sram_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_reg   <= RESET_PC - 32'd4;  // first fetch lands on RESET_PC
            redir    <= 1'b0;
            redir_pc <= '0;
        end else if (branch_taken) begin
            pc_reg   <= pc;
            redir    <= 1'b1;
            redir_pc <= target;
        end else if (!stall) begin
            pc_reg <= pc;
            redir  <= 1'b0;
        end
    end

endmodule

/* design/pipe_reg.sv */
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= payload_t'('0);
        end else if (bubble) begin
            q <= payload_t'('0);  // zero payload carries no writes
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

/* design/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_RAM, WB_LINK} wb_sel_e;

    typedef enum logic [1:0] {NPC_SEQ, NPC_BEQ, NPC_BNE, NPC_JUMP} npc_op_e;

    typedef struct packed {
        logic [mips_isa_pkg::WORD_W-1:0]     pc;
        logic [mips_isa_pkg::WORD_W-1:0]     rs_value;
        logic [mips_isa_pkg::WORD_W-1:0]     rt_value;
        logic [mips_isa_pkg::WORD_W-1:0]     imm;
        alu_op_e                             alu_op;
        logic                                b_sel;    // 1 selects imm
        logic [mips_isa_pkg::REG_ADDR_W-1:0] rd;
        logic                                rf_we;
        logic                                is_load;
        logic                                is_store;
        wb_sel_e                             wb_sel;
    } id_ex_t;

    typedef struct packed {
        logic [mips_isa_pkg::WORD_W-1:0]     pc;
        logic [mips_isa_pkg::WORD_W-1:0]     alu_result;
        logic [mips_isa_pkg::REG_ADDR_W-1:0] rd;
        logic                                rf_we;
        logic                                is_load;
        wb_sel_e                             wb_sel;
    } ex_mem_t;

    typedef struct packed {
        logic [mips_isa_pkg::WORD_W-1:0]     pc;
        logic [mips_isa_pkg::WORD_W-1:0]     alu_result;
        logic [mips_isa_pkg::REG_ADDR_W-1:0] rd;
        logic                                rf_we;
        logic                                is_load;
        wb_sel_e                             wb_sel;
        logic [mips_isa_pkg::WORD_W-1:0]     load_word;
    } mem_wb_t;

endpackage

/* design/mips_isa_pkg.sv */
package mips_isa_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    // field positions inside the instruction word
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int SA_LSB     = 6;

    localparam logic [REG_ADDR_W-1:0] REG_RA = 5'd31;  // link register

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

endpackage
